//--- sim.f
logic/mmio_pkg.sv
logic/mmio_bus_ctrl.sv
logic/dsp_multiplier.sv
logic/pad_shifter.sv
logic/flash_bitbang.sv
logic/mmio_top.sv
sim/mmio_tb.sv

//--- Makefile
# Verilator build and run for the MMIO block testbench

VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing -j 0
TOP         = mmio_tb
FILELIST    = sim.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/mmio_tb.sv
// ##########################################################
// MMIO block testbench
// Random bus traffic checked against a reference model of
// the status, multiplier, gamepad and flash registers
// ##########################################################

`timescale 1ns/1ps

module mmio_tb
    import mmio_pkg::*;
();

    localparam int TIMEOUT_CYCLES   = 20;
    localparam int EXPECTED_LATENCY = 2;
    localparam int SEED             = 54215;
    localparam int PAD_BITS         = 16;

    // Region field values in address bits 19 to 16
    localparam int STATUS_FIELD = 0;
    localparam int DSP_FIELD    = 1;
    localparam int PAD_FIELD    = 2;
    localparam int FLASH_FIELD  = 3;

    logic                      vdp_clk = 1'b0;
    logic                      vdp_reset;
    host_req_t                 host_req;
    host_rsp_t                 host_rsp;
    logic                      btn_1;
    logic                      btn_2;
    logic                      btn_3;
    logic                      led_r;
    logic                      led_b;
    flash_pins_t               flash_pins;
    logic [FLASH_IO_WIDTH-1:0] flash_io_in;

    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // Reference model state
    logic [1:0]          model_leds;
    logic [PAD_BITS-1:0] model_pad;
    logic                model_latch;
    logic                model_clk;
    logic                level_1;
    logic                level_2;
    logic                level_3;

    mmio_top dut_i (
        .vdp_clk     (vdp_clk),
        .vdp_reset   (vdp_reset),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .btn_1       (btn_1),
        .btn_2       (btn_2),
        .btn_3       (btn_3),
        .led_r       (led_r),
        .led_b       (led_b),
        .flash_pins  (flash_pins),
        .flash_io_in (flash_io_in)
    );

    always #4 vdp_clk = ~vdp_clk;

    task automatic note_error(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errs_at_start);
        end
    endtask

    function automatic logic [ADDR_WIDTH-1:0] region_addr(input int field,
                                                          input logic [15:0] low);
        return {4'(field), low};
    endfunction

    // One access with latency counted from the edge that raises valid
    task automatic bus_access(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [STRB_WIDTH-1:0] wstrb,
                              input logic [DATA_WIDTH-1:0] wdata,
                              output logic [DATA_WIDTH-1:0] rdata);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge vdp_clk);
        host_req <= '{valid: 1'b1, addr: addr, wstrb: wstrb, wdata: wdata};
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge vdp_clk);
            cycles++;
            @(negedge vdp_clk);
            seen = host_rsp.ready;
        end
        if (!seen) begin
            abort_run($sformatf("Timeout: no ready within %0d cycles for address 0x%05h",
                                TIMEOUT_CYCLES, addr));
        end else begin
            rdata = host_rsp.rdata;
            if (cycles != EXPECTED_LATENCY) begin
                note_error($sformatf("ready after %0d cycles, expected %0d, address 0x%05h",
                                     cycles, EXPECTED_LATENCY, addr));
            end
            if (wstrb != '0 && rdata !== '0) begin
                note_error($sformatf("write returned rdata 0x%08h, expected zero", rdata));
            end
            // Drop valid for at least one idle cycle
            @(posedge vdp_clk);
            host_req <= '0;
            @(negedge vdp_clk);
        end
    endtask

    task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [STRB_WIDTH-1:0] wstrb,
                             input logic [DATA_WIDTH-1:0] wdata);
        logic [DATA_WIDTH-1:0] unused_rdata;
        bus_access(addr, wstrb, wdata, unused_rdata);
    endtask

    task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr,
                            output logic [DATA_WIDTH-1:0] rdata);
        bus_access(addr, '0, $urandom(), rdata);
    endtask

    task automatic check_reset_state();
        int errs_at_start;
        errs_at_start = errors;
        if (led_r !== 1'b1 || led_b !== 1'b0) begin
            note_error($sformatf("LEDs after reset r=%b b=%b, expected r=1 b=0", led_r, led_b));
        end
        if (flash_pins.csn !== 1'b1 || flash_pins.clk !== 1'b0 || flash_pins.io_oe !== '0) begin
            note_error($sformatf("flash pins after reset csn=%b clk=%b oe=%b, expected idle",
                                 flash_pins.csn, flash_pins.clk, flash_pins.io_oe));
        end
        if (host_rsp.ready !== 1'b0) begin
            note_error("ready is high after reset");
        end
        end_test("reset values", errs_at_start);
    endtask

    task automatic drive_status_leds();
        logic [DATA_WIDTH-1:0] data;
        int                    errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < 20; i++) begin
            data = $urandom();
            bus_write(region_addr(STATUS_FIELD, 16'($urandom())),
                      4'($urandom_range(15, 1)), data);
            model_leds = data[1:0];
            if (led_r !== model_leds[0] || led_b !== model_leds[1]) begin
                note_error($sformatf("LEDs r=%b b=%b, expected r=%b b=%b",
                                     led_r, led_b, model_leds[0], model_leds[1]));
            end
        end
        end_test("status and timing", errs_at_start);
    endtask

    task automatic multiply_pairs();
        logic [15:0]           op_a;
        logic [15:0]           op_b;
        logic [15:0]           low;
        logic [DATA_WIDTH-1:0] rdata;
        logic [DATA_WIDTH-1:0] expected;
        int                    ia;
        int                    ib;
        int                    errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < 50; i++) begin
            op_a = 16'($urandom());
            op_b = 16'($urandom());
            low  = 16'($urandom());
            low[DSP_SEL_B_BIT] = 1'b0;
            bus_write(region_addr(DSP_FIELD, low), 4'hF, {16'($urandom()), op_a});
            low[DSP_SEL_B_BIT] = 1'b1;
            bus_write(region_addr(DSP_FIELD, low), 4'hF, {16'($urandom()), op_b});
            // Sign-extend both operands before the multiply
            ia       = {{16{op_a[15]}}, op_a};
            ib       = {{16{op_b[15]}}, op_b};
            expected = ia * ib;
            bus_read(region_addr(DSP_FIELD, 16'($urandom())), rdata);
            if (rdata !== expected) begin
                note_error($sformatf("product of 0x%04h and 0x%04h is 0x%08h, expected 0x%08h",
                                     op_a, op_b, rdata, expected));
            end
        end
        end_test("multiplier", errs_at_start);
    endtask

    // A rising clock bit shifts and a held latch reloads after it
    task automatic apply_pad_write(input logic new_latch, input logic new_clk);
        logic [PAD_BITS-1:0] load;
        load    = '0;
        load[7] = level_1;
        load[6] = level_3;
        load[0] = level_2;
        if (model_latch) begin
            model_pad = load;
        end
        if (new_clk && !model_clk) begin
            model_pad = model_pad >> 1;
        end
        if (new_latch) begin
            model_pad = load;
        end
        model_latch = new_latch;
        model_clk   = new_clk;
    endtask

    task automatic pad_control(input logic latch, input logic clk);
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] rdata;
        data = $urandom();
        data[PAD_LATCH_BIT] = latch;
        data[PAD_CLK_BIT]   = clk;
        bus_write(region_addr(PAD_FIELD, 16'($urandom())), 4'hF, data);
        apply_pad_write(latch, clk);
        bus_read(region_addr(PAD_FIELD, 16'($urandom())), rdata);
        if (rdata !== {31'b0, model_pad[0]}) begin
            note_error($sformatf("pad read 0x%08h, expected bit %b", rdata, model_pad[0]));
        end
    endtask

    task automatic shift_gamepad();
        int errs_at_start;
        errs_at_start = errors;
        for (int r = 0; r < 4; r++) begin
            level_1 = 1'($urandom());
            level_2 = 1'($urandom());
            level_3 = 1'($urandom());
            @(posedge vdp_clk);
            btn_1 <= level_1;
            btn_2 <= level_2;
            btn_3 <= level_3;
            pad_control(1'b1, 1'b0);
            pad_control(1'b0, 1'b0);
            for (int n = 0; n < PAD_BITS; n++) begin
                pad_control(1'b0, 1'b1);
                pad_control(1'b0, 1'b0);
            end
        end
        end_test("gamepad", errs_at_start);
    endtask

    task automatic bitbang_flash();
        logic [DATA_WIDTH-1:0]     data;
        logic [DATA_WIDTH-1:0]     rdata;
        logic [FLASH_IO_WIDTH-1:0] io;
        flash_pins_t               exp_pins;
        int                        errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < 30; i++) begin
            data = $urandom();
            bus_write(region_addr(FLASH_FIELD, 16'($urandom())), 4'hF, data);
            if (data[FLASH_ACTIVE_BIT]) begin
                exp_pins = '{clk: data[FLASH_CLK_BIT], csn: data[FLASH_CSN_BIT],
                             io_out: data[FLASH_IO_LSB +: 4], io_oe: data[FLASH_OE_LSB +: 4]};
            end else begin
                exp_pins = '{clk: 1'b0, csn: 1'b1, io_out: 4'h0, io_oe: 4'h0};
            end
            if (flash_pins !== exp_pins) begin
                note_error($sformatf("flash pins 0x%03h, expected 0x%03h after write 0x%08h",
                                     flash_pins, exp_pins, data));
            end
            io = 4'($urandom());
            @(posedge vdp_clk);
            flash_io_in <= io;
            bus_read(region_addr(FLASH_FIELD, 16'($urandom())), rdata);
            if (rdata !== {28'b0, io}) begin
                note_error($sformatf("flash read 0x%08h, expected 0x%08h", rdata, {28'b0, io}));
            end
        end
        end_test("flash bit-bang", errs_at_start);
    endtask

    task automatic read_unmapped();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rdata;
        int                    errs_at_start;
        errs_at_start = errors;
        for (int i = 0; i < 20; i++) begin
            addr = region_addr(int'($urandom_range(15, 4)), 16'($urandom()));
            bus_read(addr, rdata);
            if (rdata !== '0) begin
                note_error($sformatf("read of 0x%05h returned 0x%08h, expected zero",
                                     addr, rdata));
            end
        end
        end_test("unmapped reads", errs_at_start);
    endtask

    initial begin
        void'($urandom(SEED));
        vdp_reset   <= 1'b1;
        host_req    <= '0;
        btn_1       <= 1'b0;
        btn_2       <= 1'b0;
        btn_3       <= 1'b0;
        flash_io_in <= '0;
        model_leds  = STATUS_RESET;
        model_pad   = '0;
        model_latch = 1'b0;
        model_clk   = 1'b0;
        repeat (8) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        @(negedge vdp_clk);

        check_reset_state();
        drive_status_leds();
        multiply_pairs();
        shift_gamepad();
        bitbang_flash();
        read_unmapped();

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/mmio_top.sv
// ##########################################################
// MMIO peripheral block
// Bus control with the multiplier, gamepad shifter and
// flash bit-bang port behind it
// ##########################################################

`timescale 1ns/1ps

module mmio_top
    import mmio_pkg::*;
(
    input  logic                      vdp_clk,
    input  logic                      vdp_reset,

    input  host_req_t                 host_req,
    output host_rsp_t                 host_rsp,

    input  logic                      btn_1,
    input  logic                      btn_2,
    input  logic                      btn_3,

    output logic                      led_r,
    output logic                      led_b,

    output flash_pins_t               flash_pins,
    input  logic [FLASH_IO_WIDTH-1:0] flash_io_in
);

    localparam int OPERAND_WIDTH = 16;
    localparam int PAD_BITS      = 16;

    logic                      dsp_write_a;
    logic                      dsp_write_b;
    logic                      pad_write;
    logic                      flash_write;
    logic [DATA_WIDTH-1:0]     write_data;
    logic [DATA_WIDTH-1:0]     product;
    logic                      pad_bit;
    logic [FLASH_IO_WIDTH-1:0] flash_sample;

    mmio_bus_ctrl bus_ctrl_i (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .dsp_write_a  (dsp_write_a),
        .dsp_write_b  (dsp_write_b),
        .pad_write    (pad_write),
        .flash_write  (flash_write),
        .write_data   (write_data),
        .product      (product),
        .pad_bit      (pad_bit),
        .flash_sample (flash_sample),
        .led_r        (led_r),
        .led_b        (led_b)
    );

    // Operands come from the low half of the write data
    dsp_multiplier #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) dsp_i (
        .vdp_clk (vdp_clk),
        .write_a (dsp_write_a),
        .write_b (dsp_write_b),
        .operand (write_data[OPERAND_WIDTH-1:0]),
        .product (product)
    );

    pad_shifter #(
        .PAD_BITS (PAD_BITS)
    ) pad_i (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .pad_write  (pad_write),
        .write_data (write_data),
        .btn_1      (btn_1),
        .btn_2      (btn_2),
        .btn_3      (btn_3),
        .pad_bit    (pad_bit)
    );

    flash_bitbang flash_i (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .flash_write  (flash_write),
        .write_data   (write_data),
        .flash_io_in  (flash_io_in),
        .flash_pins   (flash_pins),
        .flash_sample (flash_sample)
    );

endmodule

//--- logic/flash_bitbang.sv
// ##########################################################
// Flash bit-bang port
// Software-driven clock, chip select and quad IO lines that
// stay idle whenever bit-bang mode is off
// ##########################################################

`timescale 1ns/1ps

module flash_bitbang
    import mmio_pkg::*;
(
    input  logic                      vdp_clk,
    input  logic                      vdp_reset,

    input  logic                      flash_write,
    input  logic [DATA_WIDTH-1:0]     write_data,

    input  logic [FLASH_IO_WIDTH-1:0] flash_io_in,
    output flash_pins_t               flash_pins,
    output logic [FLASH_IO_WIDTH-1:0] flash_sample
);

    logic        active_q;
    flash_pins_t fields_q;

    // Pin fields from the last control write
    always_ff @(posedge vdp_clk) begin
        if (flash_write) begin
            fields_q.io_out <= write_data[FLASH_IO_LSB +: FLASH_IO_WIDTH];
            fields_q.io_oe  <= write_data[FLASH_OE_LSB +: FLASH_IO_WIDTH];
            fields_q.clk    <= write_data[FLASH_CLK_BIT];
            fields_q.csn    <= write_data[FLASH_CSN_BIT];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active_q <= 1'b0;
        end else if (flash_write) begin
            active_q <= write_data[FLASH_ACTIVE_BIT];
        end
    end

    // Deselected and undriven while inactive
    always_comb begin
        if (active_q) begin
            flash_pins = fields_q;
        end else begin
            flash_pins.clk    = 1'b0;
            flash_pins.csn    = 1'b1;
            flash_pins.io_out = '0;
            flash_pins.io_oe  = '0;
        end
    end

    // IO lines sampled every cycle for software reads
    always_ff @(posedge vdp_clk) begin
        flash_sample <= flash_io_in;
    end

endmodule

//--- logic/pad_shifter.sv
// ##########################################################
// Gamepad shifter
// Loads the board buttons under software latch and clock
// control and shifts them out one bit at a time
// ##########################################################

`timescale 1ns/1ps

module pad_shifter
    import mmio_pkg::*;
#(
    parameter int PAD_BITS = 16
) (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  pad_write,
    input  logic [DATA_WIDTH-1:0] write_data,

    input  logic                  btn_1,
    input  logic                  btn_2,
    input  logic                  btn_3,

    output logic                  pad_bit
);

    logic                pad_latch;
    logic                pad_clk;
    logic                pad_clk_q;
    logic                pad_shift;
    logic [PAD_BITS-1:0] pad_load;
    logic [PAD_BITS-1:0] pad_q;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
            pad_clk_q <= 1'b0;
        end else begin
            if (pad_write) begin
                pad_latch <= write_data[PAD_LATCH_BIT];
                pad_clk   <= write_data[PAD_CLK_BIT];
            end
            pad_clk_q <= pad_clk;
        end
    end

    assign pad_shift = pad_clk && !pad_clk_q;

    // Left, right and B buttons in their controller positions
    always_comb begin
        pad_load    = '0;
        pad_load[7] = btn_1;
        pad_load[6] = btn_3;
        pad_load[0] = btn_2;
    end

    always_ff @(posedge vdp_clk) begin
        if (pad_shift) begin
            pad_q <= {1'b0, pad_q[PAD_BITS-1:1]};
        end else if (pad_latch) begin
            pad_q <= pad_load;
        end
    end

    assign pad_bit = pad_q[0];

endmodule

//--- logic/dsp_multiplier.sv
// ##########################################################
// DSP multiplier
// Two signed operand registers and a registered product
// ##########################################################

`timescale 1ns/1ps

module dsp_multiplier #(
    parameter int OPERAND_WIDTH = 16
) (
    input  logic                         vdp_clk,

    input  logic                         write_a,
    input  logic                         write_b,
    input  logic [OPERAND_WIDTH-1:0]     operand,

    output logic [2*OPERAND_WIDTH-1:0]   product
);

    logic [OPERAND_WIDTH-1:0] mult_a;
    logic [OPERAND_WIDTH-1:0] mult_b;

    // Flat enables keep the operands in the MAC block input registers
    always_ff @(posedge vdp_clk) begin
        if (write_a) begin
            mult_a <= operand;
        end

        if (write_b) begin
            mult_b <= operand;
        end
    end

    // Signed product is ready one cycle after an operand changes
    always_ff @(posedge vdp_clk) begin
        product <= $signed(mult_a) * $signed(mult_b);
    end

endmodule

//--- logic/mmio_bus_ctrl.sv
// ##########################################################
// MMIO bus control
// Decodes the region of each request, issues one-cycle
// write strobes, holds the status LEDs and returns ready
// with the read data two cycles after valid rises
// ##########################################################

`timescale 1ns/1ps

module mmio_bus_ctrl
    import mmio_pkg::*;
(
    input  logic                      vdp_clk,
    input  logic                      vdp_reset,

    input  host_req_t                 host_req,
    output host_rsp_t                 host_rsp,

    output logic                      dsp_write_a,
    output logic                      dsp_write_b,
    output logic                      pad_write,
    output logic                      flash_write,
    output logic [DATA_WIDTH-1:0]     write_data,

    input  logic [DATA_WIDTH-1:0]     product,
    input  logic                      pad_bit,
    input  logic [FLASH_IO_WIDTH-1:0] flash_sample,

    output logic                      led_r,
    output logic                      led_b
);

    logic                  valid_q;
    logic                  start_q;
    logic                  status_write;
    logic                  is_write_q;
    mmio_region_e          region_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [1:0]            status_q;
    logic                  ready_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [DATA_WIDTH-1:0] read_value;

    logic         new_req;
    logic         req_is_write;
    mmio_region_e req_region;

    // Only the first cycle of a held valid starts an access
    assign new_req      = host_req.valid && !valid_q;
    assign req_is_write = |host_req.wstrb;
    assign req_region   = decode_region(host_req.addr);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            valid_q      <= 1'b0;
            start_q      <= 1'b0;
            status_write <= 1'b0;
            dsp_write_a  <= 1'b0;
            dsp_write_b  <= 1'b0;
            pad_write    <= 1'b0;
            flash_write  <= 1'b0;
        end else begin
            valid_q      <= host_req.valid;
            start_q      <= new_req;
            status_write <= new_req && req_is_write && (req_region == REGION_STATUS);
            dsp_write_a  <= new_req && req_is_write && (req_region == REGION_DSP) &&
                            !host_req.addr[DSP_SEL_B_BIT];
            dsp_write_b  <= new_req && req_is_write && (req_region == REGION_DSP) &&
                            host_req.addr[DSP_SEL_B_BIT];
            pad_write    <= new_req && req_is_write && (req_region == REGION_PAD);
            flash_write  <= new_req && req_is_write && (req_region == REGION_FLASH);
        end
    end

    // Request payload held for the datapath modules
    always_ff @(posedge vdp_clk) begin
        if (new_req) begin
            is_write_q <= req_is_write;
            region_q   <= req_region;
            wdata_q    <= host_req.wdata;
        end
    end

    assign write_data = wdata_q;

    // Status LEDs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status_q <= STATUS_RESET;
        end else if (status_write) begin
            status_q <= wdata_q[1:0];
        end
    end

    assign led_r = status_q[0];
    assign led_b = status_q[1];

    // Read data per region with zero for writes
    always_comb begin
        read_value = '0;
        if (!is_write_q) begin
            case (region_q)
                REGION_DSP:   read_value = product;
                REGION_PAD:   read_value[0] = pad_bit;
                REGION_FLASH: read_value[FLASH_IO_WIDTH-1:0] = flash_sample;
                default:      read_value = '0;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= start_q;
        end
    end

    always_ff @(posedge vdp_clk) begin
        rdata_q <= read_value;
    end

    assign host_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

//--- logic/mmio_pkg.sv
// ##########################################################
// MMIO peripheral definitions
// Bus request and response structs, region map, register
// field positions and the widths shared by the MMIO block
// ##########################################################

package mmio_pkg;

    // Bus and pin widths
    localparam int ADDR_WIDTH     = 20;
    localparam int DATA_WIDTH     = 32;
    localparam int STRB_WIDTH     = 4;
    localparam int FLASH_IO_WIDTH = 4;

    // Region field in the address
    localparam int REGION_LSB   = 16;
    localparam int REGION_WIDTH = 4;

    // DSP operand select
    localparam int DSP_SEL_B_BIT = 2;

    // Flash control write fields
    localparam int FLASH_IO_LSB     = 0;
    localparam int FLASH_OE_LSB     = 4;
    localparam int FLASH_CLK_BIT    = 8;
    localparam int FLASH_CSN_BIT    = 9;
    localparam int FLASH_ACTIVE_BIT = 15;

    // Pad control write fields
    localparam int PAD_LATCH_BIT = 0;
    localparam int PAD_CLK_BIT   = 1;

    // LED state out of reset with red on
    localparam logic [1:0] STATUS_RESET = 2'b01;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;
        logic [STRB_WIDTH-1:0] wstrb;
        logic [DATA_WIDTH-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic                  ready;
        logic [DATA_WIDTH-1:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic                      clk;
        logic                      csn;
        logic [FLASH_IO_WIDTH-1:0] io_out;
        logic [FLASH_IO_WIDTH-1:0] io_oe;
    } flash_pins_t;

    typedef enum logic [2:0] {
        REGION_STATUS,
        REGION_DSP,
        REGION_PAD,
        REGION_FLASH,
        REGION_NONE
    } mmio_region_e;

    // Upper address nibble selects the peripheral
    function automatic mmio_region_e decode_region(input logic [ADDR_WIDTH-1:0] addr);
        logic [REGION_WIDTH-1:0] field;
        field = addr[REGION_LSB +: REGION_WIDTH];
        case (field)
            4'd0:    return REGION_STATUS;
            4'd1:    return REGION_DSP;
            4'd2:    return REGION_PAD;
            4'd3:    return REGION_FLASH;
            default: return REGION_NONE;
        endcase
    endfunction

endpackage
